// File: logic/softmax_cfg_pkg.sv
package softmax_cfg_pkg;

    // Score lanes carried by one beat
    localparam int unsigned N_LANES = 4;

    localparam int unsigned SCORE_W = 8;

    // Fractional bits of exponentials and probabilities
    localparam int unsigned FRAC_W = 8;

    // Exponential of the maximum is exactly one, so one integer bit is needed
    localparam int unsigned EXP_W = FRAC_W + 1;

    typedef logic signed [SCORE_W-1:0] score_t;

    typedef logic [EXP_W-1:0] exp_t;

    // Covers max minus min over the signed score range
    typedef logic [SCORE_W-1:0] shift_t;

endpackage

// File: logic/softmax_ctrl_pkg.sv
package softmax_ctrl_pkg;

    typedef enum logic {
        PH_ACCUM,
        PH_NORM
    } phase_e;

    typedef struct packed {
        softmax_cfg_pkg::score_t [softmax_cfg_pkg::N_LANES-1:0] lanes;
        logic [softmax_cfg_pkg::N_LANES-1:0]                    strb;
        logic                                                   last;
    } score_beat_t;

    // Rescale is the rise of the maximum caused by this beat
    typedef struct packed {
        softmax_cfg_pkg::exp_t [softmax_cfg_pkg::N_LANES-1:0] lanes;
        logic [softmax_cfg_pkg::N_LANES-1:0]                  strb;
        logic                                                 last;
        softmax_cfg_pkg::shift_t                              rescale;
    } exp_beat_t;

    typedef struct packed {
        softmax_cfg_pkg::exp_t [softmax_cfg_pkg::N_LANES-1:0] lanes;
        logic [softmax_cfg_pkg::N_LANES-1:0]                  strb;
        logic                                                 last;
    } prob_beat_t;

    typedef struct packed {
        phase_e                  phase;
        softmax_cfg_pkg::score_t max;
        logic                    denom_valid;
    } softmax_status_t;

endpackage

// File: logic/softmax_max_tracker.sv
`timescale 1ns/100ps

module softmax_max_tracker (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  softmax_ctrl_pkg::score_beat_t in_beat_i,
    input  softmax_ctrl_pkg::phase_e      phase_i,
    input  logic                          exp_ready_i,
    output logic                          exp_valid_o,
    output softmax_ctrl_pkg::score_beat_t exp_beat_o,
    output softmax_cfg_pkg::score_t       ref_max_o,
    output softmax_cfg_pkg::shift_t       rescale_o,
    output softmax_cfg_pkg::score_t       max_o
);
    import softmax_cfg_pkg::*;
    import softmax_ctrl_pkg::*;

    localparam score_t SCORE_MIN = score_t'({1'b1, {(SCORE_W-1){1'b0}}});

    score_t max_q;
    score_t beat_max;
    score_t new_max;
    phase_e phase_q;
    logic   sealed_q;
    logic   accept;
    logic   phase_change;

    // Sealed after the last beat of a pass until the phase moves on
    assign in_ready_o   = exp_ready_i & ~sealed_q;
    assign exp_valid_o  = in_valid_i & ~sealed_q;
    assign exp_beat_o   = in_beat_i;
    assign accept       = in_valid_i & in_ready_o;
    assign phase_change = (phase_q != phase_i);

    always_comb begin
        score_t lane;
        beat_max = SCORE_MIN;
        for (int i = 0; i < N_LANES; i++) begin
            lane = in_beat_i.lanes[i];
            if (in_beat_i.strb[i] && lane > beat_max) begin
                beat_max = lane;
            end
        end
    end

    // Maximum only moves during accumulation
    always_comb begin
        new_max = max_q;
        if (phase_i == PH_ACCUM && beat_max > max_q) begin
            new_max = beat_max;
        end
    end

    assign ref_max_o = new_max;
    assign rescale_o = (phase_i == PH_ACCUM) ? shift_t'(new_max - max_q) : '0;
    assign max_o     = max_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            max_q    <= SCORE_MIN;
            phase_q  <= PH_ACCUM;
            sealed_q <= 1'b0;
        end else begin
            phase_q <= phase_i;
            if (phase_change) begin
                sealed_q <= 1'b0;
            end else if (accept && in_beat_i.last) begin
                sealed_q <= 1'b1;
            end
            if (phase_change && phase_i == PH_ACCUM) begin
                max_q <= SCORE_MIN;
            end else if (accept) begin
                max_q <= new_max;
            end
        end
    end

endmodule

// File: logic/softmax_exp2_lanes.sv
`timescale 1ns/100ps

module softmax_exp2_lanes (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  softmax_ctrl_pkg::score_beat_t in_beat_i,
    input  softmax_cfg_pkg::score_t       ref_max_i,
    input  softmax_cfg_pkg::shift_t       rescale_i,
    output logic                          out_valid_o,
    input  logic                          out_ready_i,
    output softmax_ctrl_pkg::exp_beat_t   out_beat_o
);
    import softmax_cfg_pkg::*;
    import softmax_ctrl_pkg::*;

    exp_beat_t beat_d;
    exp_beat_t beat_q;
    logic      valid_q;
    logic      accept;

    assign in_ready_o  = ~valid_q | out_ready_i;
    assign accept      = in_valid_i & in_ready_o;
    assign out_valid_o = valid_q;
    assign out_beat_o  = beat_q;

    always_comb begin
        logic signed [SCORE_W:0] gap;
        beat_d.strb    = in_beat_i.strb;
        beat_d.last    = in_beat_i.last;
        beat_d.rescale = rescale_i;
        for (int i = 0; i < N_LANES; i++) begin
            gap = {ref_max_i[SCORE_W-1], ref_max_i}
                - {in_beat_i.lanes[i][SCORE_W-1], in_beat_i.lanes[i]};
            // 2^(score - max) in fixed point underflows to zero past FRAC_W
            if (in_beat_i.strb[i] && !gap[SCORE_W] && gap <= FRAC_W) begin
                beat_d.lanes[i] = exp_t'(1) << (FRAC_W - gap[SCORE_W-1:0]);
            end else begin
                beat_d.lanes[i] = '0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            beat_q <= beat_d;
        end
    end

endmodule

// File: logic/softmax_denom_acc.sv
`timescale 1ns/100ps

module softmax_denom_acc #(
    parameter int unsigned ACC_W = 20
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  softmax_ctrl_pkg::exp_beat_t in_beat_i,
    input  logic                        norm_done_i,
    output softmax_ctrl_pkg::phase_e    phase_o,
    output logic [ACC_W-1:0]            denom_o,
    output logic                        denom_valid_o
);
    import softmax_cfg_pkg::*;
    import softmax_ctrl_pkg::*;

    phase_e             phase_q;
    logic [ACC_W-1:0]   acc_q;
    logic [ACC_W-1:0]   acc_scaled;
    logic [ACC_W-1:0]   beat_sum;
    logic               accept;

    assign in_ready_o    = (phase_q == PH_ACCUM);
    assign accept        = in_valid_i & in_ready_o;
    assign phase_o       = phase_q;
    assign denom_o       = acc_q;
    assign denom_valid_o = (phase_q == PH_NORM);

    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < N_LANES; i++) begin
            beat_sum = beat_sum + ACC_W'(in_beat_i.lanes[i]);
        end
    end

    // Earlier terms were taken against a lower maximum
    always_comb begin
        if (in_beat_i.rescale >= ACC_W) begin
            acc_scaled = '0;
        end else begin
            acc_scaled = acc_q >> in_beat_i.rescale;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q <= PH_ACCUM;
            acc_q   <= '0;
        end else begin
            case (phase_q)
                PH_ACCUM: begin
                    if (accept) begin
                        acc_q <= acc_scaled + beat_sum;
                        if (in_beat_i.last) begin
                            phase_q <= PH_NORM;
                        end
                    end
                end
                PH_NORM: begin
                    if (norm_done_i) begin
                        acc_q   <= '0;
                        phase_q <= PH_ACCUM;
                    end
                end
            endcase
        end
    end

endmodule

// File: logic/softmax_norm_divider.sv
`timescale 1ns/100ps

module softmax_norm_divider #(
    parameter int unsigned ACC_W = 20
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  softmax_ctrl_pkg::exp_beat_t in_beat_i,
    input  logic [ACC_W-1:0]            denom_i,
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output softmax_ctrl_pkg::prob_beat_t out_beat_o
);
    import softmax_cfg_pkg::*;
    import softmax_ctrl_pkg::*;

    // Spare top quotient bit stays zero since exp never exceeds the denominator
    localparam int unsigned QUOT_W = EXP_W + 1;
    localparam int unsigned DVD_W  = EXP_W + FRAC_W;
    localparam int unsigned CNT_W  = $clog2(QUOT_W);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_HOLD
    } div_state_e;

    div_state_e         state_q;
    logic [CNT_W-1:0]   bit_cnt_q;
    logic [DVD_W-1:0]   dvd [N_LANES];
    logic [ACC_W-1:0]   rem_q [N_LANES];
    logic [ACC_W-1:0]   rem_d [N_LANES];
    logic [QUOT_W-1:0]  quot_q [N_LANES];
    logic [N_LANES-1:0] qbit;
    logic [N_LANES-1:0] strb_q;
    logic               last_q;
    logic               accept;

    assign in_ready_o  = (state_q == DIV_IDLE);
    assign accept      = in_valid_i & in_ready_o;
    assign out_valid_o = (state_q == DIV_HOLD);

    // Upper dividend bits lie below the denominator and preload the remainder
    always_comb begin
        logic [ACC_W:0] trial;
        for (int i = 0; i < N_LANES; i++) begin
            dvd[i]   = {in_beat_i.lanes[i], {FRAC_W{1'b0}}};
            trial    = {rem_q[i], quot_q[i][QUOT_W-1]};
            qbit[i]  = (trial >= {1'b0, denom_i});
            rem_d[i] = qbit[i] ? ACC_W'(trial - {1'b0, denom_i}) : trial[ACC_W-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= DIV_IDLE;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (accept) begin
                        state_q   <= DIV_RUN;
                        bit_cnt_q <= '0;
                    end
                end
                DIV_RUN: begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == CNT_W'(QUOT_W - 1)) begin
                        state_q <= DIV_HOLD;
                    end
                end
                DIV_HOLD: begin
                    if (out_ready_i) begin
                        state_q <= DIV_IDLE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            strb_q <= in_beat_i.strb;
            last_q <= in_beat_i.last;
            for (int i = 0; i < N_LANES; i++) begin
                rem_q[i]  <= ACC_W'(dvd[i][DVD_W-1:QUOT_W]);
                quot_q[i] <= dvd[i][QUOT_W-1:0];
            end
        end else if (state_q == DIV_RUN) begin
            for (int i = 0; i < N_LANES; i++) begin
                rem_q[i]  <= rem_d[i];
                quot_q[i] <= {quot_q[i][QUOT_W-2:0], qbit[i]};
            end
        end
    end

    always_comb begin
        out_beat_o.strb = strb_q;
        out_beat_o.last = last_q;
        for (int i = 0; i < N_LANES; i++) begin
            out_beat_o.lanes[i] = quot_q[i][EXP_W-1:0];
        end
    end

endmodule

// File: logic/softmax_top.sv
`timescale 1ns/100ps

module softmax_top #(
    parameter int unsigned ACC_W = 20
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              in_valid_i,
    output logic                              in_ready_o,
    input  softmax_ctrl_pkg::score_beat_t     in_beat_i,
    output logic                              out_valid_o,
    input  logic                              out_ready_i,
    output softmax_ctrl_pkg::prob_beat_t      out_beat_o,
    output softmax_ctrl_pkg::softmax_status_t status_o
);
    import softmax_cfg_pkg::*;
    import softmax_ctrl_pkg::*;

    logic             trk_valid;
    logic             trk_ready;
    score_beat_t      trk_beat;
    score_t           ref_max;
    shift_t           rescale;
    score_t           cur_max;

    logic             exp_valid;
    logic             exp_ready;
    exp_beat_t        exp_beat;

    logic             acc_valid;
    logic             acc_ready;
    logic             div_valid;
    logic             div_ready;

    phase_e           cur_phase;
    logic [ACC_W-1:0] denom;
    logic             denom_valid;
    logic             norm_done;

    // Exponentials feed the sum in pass one and the divider in pass two
    assign acc_valid = exp_valid & (cur_phase == PH_ACCUM);
    assign div_valid = exp_valid & (cur_phase == PH_NORM);
    assign exp_ready = (cur_phase == PH_ACCUM) ? acc_ready : div_ready;

    assign norm_done = out_valid_o & out_ready_i & out_beat_o.last;

    assign status_o = '{phase: cur_phase, max: cur_max, denom_valid: denom_valid};

    softmax_max_tracker i_max_tracker (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_beat_i   (in_beat_i),
        .phase_i     (cur_phase),
        .exp_ready_i (trk_ready),
        .exp_valid_o (trk_valid),
        .exp_beat_o  (trk_beat),
        .ref_max_o   (ref_max),
        .rescale_o   (rescale),
        .max_o       (cur_max)
    );

    softmax_exp2_lanes i_exp2_lanes (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (trk_valid),
        .in_ready_o  (trk_ready),
        .in_beat_i   (trk_beat),
        .ref_max_i   (ref_max),
        .rescale_i   (rescale),
        .out_valid_o (exp_valid),
        .out_ready_i (exp_ready),
        .out_beat_o  (exp_beat)
    );

    softmax_denom_acc #(
        .ACC_W (ACC_W)
    ) i_denom_acc (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .in_valid_i    (acc_valid),
        .in_ready_o    (acc_ready),
        .in_beat_i     (exp_beat),
        .norm_done_i   (norm_done),
        .phase_o       (cur_phase),
        .denom_o       (denom),
        .denom_valid_o (denom_valid)
    );

    softmax_norm_divider #(
        .ACC_W (ACC_W)
    ) i_norm_divider (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (div_valid),
        .in_ready_o  (div_ready),
        .in_beat_i   (exp_beat),
        .denom_i     (denom),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_beat_o  (out_beat_o)
    );

endmodule

// File: verif/softmax_tb_tests.svh
`ifndef SOFTMAX_TB_TESTS_SVH
`define SOFTMAX_TB_TESTS_SVH

task automatic test_reset_state();
    check_equal("status_o.phase", int'(status_o.phase), int'(PH_ACCUM));
    check_equal("status_o.denom_valid", int'(status_o.denom_valid), 0);
    check_equal("out_valid_o", int'(out_valid_o), 0);
    check_equal("in_ready_o", int'(in_ready_o), 1);
endtask

// Lane 3 sits more than FRAC_W below the maximum and underflows
task automatic test_single_beat();
    set_q.delete();
    set_q.push_back(make_beat(0, -1, -3, -9, 4'hf, 1'b1));
    run_set();
endtask

task automatic test_rising_max();
    set_q.delete();
    set_q.push_back(make_beat(-6, -5, -7, -8, 4'hf, 1'b0));
    set_q.push_back(make_beat(-2, -4, -1, -3, 4'hf, 1'b0));
    set_q.push_back(make_beat(3, 0, 1, 2, 4'hf, 1'b1));
    run_set();
endtask

// Masked lanes hold the largest scores, so a leak would move the maximum
task automatic test_masked_lanes();
    set_q.delete();
    set_q.push_back(make_beat(5, 100, -2, 0, 4'b1101, 1'b0));
    set_q.push_back(make_beat(120, 4, 6, 1, 4'b1110, 1'b1));
    run_set();
endtask

task automatic test_random_backpressure();
    int                 n_beats;
    logic [N_LANES-1:0] strb;
    int                 s [N_LANES];
    bp_enable = 1'b1;
    for (int set_idx = 0; set_idx < 4; set_idx++) begin
        n_beats = 1 + int'($urandom_range(3));
        set_q.delete();
        for (int b = 0; b < n_beats; b++) begin
            strb = N_LANES'($urandom_range(15, 1));
            for (int i = 0; i < N_LANES; i++) begin
                s[i] = int'($urandom_range(40)) - 20;
            end
            set_q.push_back(make_beat(s[0], s[1], s[2], s[3], strb, b == n_beats - 1));
        end
        run_set();
    end
    bp_enable = 1'b0;
endtask

`endif

// File: verif/softmax_tb.sv
`timescale 1ns/100ps

module softmax_tb;
    import softmax_cfg_pkg::*;
    import softmax_ctrl_pkg::*;

    localparam int unsigned ACC_W       = 20;
    localparam int unsigned CLK_NS      = 8;
    localparam int unsigned N_TESTS     = 5;
    localparam int unsigned TEST_BEATS  = 32;
    localparam int unsigned WATCHDOG_NS = N_TESTS * TEST_BEATS * (EXP_W + 8) * CLK_NS * 4;
    localparam int unsigned WAIT_CYCLES = 400;
    localparam int          SCORE_MIN   = -(1 << (int'(SCORE_W) - 1));

    logic            clk_i;
    logic            rst_ni;
    logic            in_valid_i;
    logic            in_ready_o;
    score_beat_t     in_beat_i;
    logic            out_valid_o;
    logic            out_ready_i;
    prob_beat_t      out_beat_o;
    softmax_status_t status_o;

    int unsigned error_count = 0;
    int unsigned check_count = 0;
    logic        bp_enable;
    score_beat_t set_q[$];
    prob_beat_t  expect_q[$];
    int          expect_max;

    // Back-pressure pattern, drawn once from the seeded generator
    logic        ready_pattern [256];
    int unsigned cycle_count;

    softmax_top #(
        .ACC_W (ACC_W)
    ) i_softmax_top (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_beat_i   (in_beat_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_beat_o  (out_beat_o),
        .status_o    (status_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_NS / 2) clk_i = ~clk_i;

    initial begin
        out_ready_i = 1'b1;
        cycle_count = 0;
        forever begin
            @(negedge clk_i);
            cycle_count++;
            out_ready_i = bp_enable ? ready_pattern[cycle_count % 256] : 1'b1;
        end
    end

    always @(posedge clk_i) begin
        if (rst_ni && out_valid_o && out_ready_i) begin
            compare_output(out_beat_o);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        error_count++;
        $display("timeout: run still busy after %0d ns", WATCHDOG_NS);
        report_and_finish();
    end

    task automatic report_and_finish();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic check_equal(input string name, input int got, input int expected);
        check_count++;
        assert (got == expected) else begin
            error_count++;
            $display("mismatch at %0d ns: %s expected %0d got %0d",
                     $time, name, expected, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_count++;
        assert (cond) else begin
            error_count++;
            $display("error at %0d ns: %s", $time, what);
        end
    endtask

    // 2^(score - max) with FRAC_W fractional bits
    function automatic int exp2_fixed(input int max_v, input int score, input logic strb);
        int gap;
        gap = max_v - score;
        if (!strb || gap > int'(FRAC_W)) begin
            return 0;
        end
        return 1 << (int'(FRAC_W) - gap);
    endfunction

    function automatic void model_set();
        int         max_v;
        int         new_max;
        int         denom;
        score_t     s;
        prob_beat_t pb;
        max_v = SCORE_MIN;
        denom = 0;
        foreach (set_q[b]) begin
            new_max = max_v;
            for (int i = 0; i < N_LANES; i++) begin
                s = set_q[b].lanes[i];
                if (set_q[b].strb[i] && int'(s) > new_max) begin
                    new_max = int'(s);
                end
            end
            // Older terms shrink by the rise of the maximum before the new ones add in
            if (new_max - max_v >= int'(ACC_W)) begin
                denom = 0;
            end else begin
                denom = denom >> (new_max - max_v);
            end
            for (int i = 0; i < N_LANES; i++) begin
                s = set_q[b].lanes[i];
                denom = denom + exp2_fixed(new_max, int'(s), set_q[b].strb[i]);
            end
            denom = denom & ((1 << ACC_W) - 1);
            max_v = new_max;
        end
        expect_max = max_v;
        foreach (set_q[b]) begin
            pb.strb = set_q[b].strb;
            pb.last = set_q[b].last;
            for (int i = 0; i < N_LANES; i++) begin
                s = set_q[b].lanes[i];
                pb.lanes[i] = exp_t'((exp2_fixed(max_v, int'(s), set_q[b].strb[i])
                                      << FRAC_W) / denom);
            end
            expect_q.push_back(pb);
        end
    endfunction

    task automatic compare_output(input prob_beat_t got);
        prob_beat_t want;
        if (expect_q.size() == 0) begin
            check_true(1'b0, "output beat arrived with no beat expected");
        end else begin
            want = expect_q.pop_front();
            for (int i = 0; i < N_LANES; i++) begin
                check_equal($sformatf("out_beat_o.lanes[%0d]", i),
                            int'(got.lanes[i]), int'(want.lanes[i]));
            end
            check_equal("out_beat_o.strb", int'(got.strb), int'(want.strb));
            check_equal("out_beat_o.last", int'(got.last), int'(want.last));
        end
    endtask

    function automatic score_beat_t make_beat(input int s0, input int s1, input int s2,
                                              input int s3, input logic [N_LANES-1:0] strb,
                                              input logic last);
        score_beat_t beat;
        beat.lanes[0] = score_t'(s0);
        beat.lanes[1] = score_t'(s1);
        beat.lanes[2] = score_t'(s2);
        beat.lanes[3] = score_t'(s3);
        beat.strb     = strb;
        beat.last     = last;
        return beat;
    endfunction

    task automatic send_beat(input score_beat_t beat);
        int unsigned waited;
        waited = 0;
        @(negedge clk_i);
        in_valid_i = 1'b1;
        in_beat_i  = beat;
        @(posedge clk_i);
        while (!in_ready_o && waited < WAIT_CYCLES) begin
            waited++;
            @(posedge clk_i);
        end
        check_true(in_ready_o, "in_ready_o never rose for a waiting input beat");
    endtask

    task automatic send_pass();
        foreach (set_q[b]) begin
            send_beat(set_q[b]);
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    // Input stays blocked until the DUT leaves the phase of the finished pass
    task automatic wait_sealed(input phase_e pass_phase);
        int unsigned waited;
        waited = 0;
        while (status_o.phase == pass_phase && waited < WAIT_CYCLES) begin
            check_true(!in_ready_o, "in_ready_o rose before the phase changed");
            waited++;
            @(negedge clk_i);
        end
        check_true(status_o.phase != pass_phase, "phase did not change after the pass");
    endtask

    task automatic run_set();
        score_t got_max;
        model_set();
        send_pass();
        wait_sealed(PH_ACCUM);
        got_max = status_o.max;
        check_equal("status_o.max", int'(got_max), expect_max);
        check_equal("status_o.denom_valid", int'(status_o.denom_valid), 1);
        send_pass();
        wait_sealed(PH_NORM);
        check_true(expect_q.size() == 0, "output beats missing at the end of pass two");
        expect_q.delete();
        check_equal("status_o.phase", int'(status_o.phase), int'(PH_ACCUM));
        check_equal("status_o.denom_valid", int'(status_o.denom_valid), 0);
    endtask

    `include "softmax_tb_tests.svh"

    initial begin
        void'($urandom(32'hfc97));
        foreach (ready_pattern[i]) begin
            ready_pattern[i] = ($urandom_range(3) != 0);
        end
        bp_enable  = 1'b0;
        rst_ni     = 1'b0;
        in_valid_i = 1'b0;
        in_beat_i  = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        test_reset_state();
        test_single_beat();
        test_rising_max();
        test_masked_lanes();
        test_random_backpressure();
        report_and_finish();
    end

endmodule

// File: all.f
+incdir+verif
logic/softmax_cfg_pkg.sv
logic/softmax_ctrl_pkg.sv
logic/softmax_max_tracker.sv
logic/softmax_exp2_lanes.sv
logic/softmax_denom_acc.sv
logic/softmax_norm_divider.sv
logic/softmax_top.sv
verif/softmax_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module softmax_tb -f all.f -o softmax_sim \
    && ./obj_dir/softmax_sim > sim.log 2>&1

grep -qx "PASS: all tests" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
